// ==== rr_storage_backend.f ====
+incdir+rtl
rtl/rr_pkg.sv
rtl/rr_record_gate.sv
rtl/rr_log_buffer.sv
rtl/rr_replay_parser.sv
rtl/rr_channel_replayer.sv
rtl/rr_storage_backend.sv
dv/rr_storage_backend_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and decide on the pass line in the output
verilator --binary --timing --assert -Wno-fatal \
  --top-module rr_storage_backend_tb -f rr_storage_backend.f \
  && ./obj_dir/Vrr_storage_backend_tb | tee /dev/stderr | grep -q "^Simulation passed$" \
  && echo "run.sh: PASS" \
  || { echo "run.sh: FAIL"; exit 1; }

// ==== dv/rr_storage_backend_tb.sv ====
`timescale 1ns/10ps
`include "rr_settings.svh"

module rr_storage_backend_tb;

  localparam int CNT_W     = $clog2(`RR_BUF_DEPTH + 1);
  localparam int MAX_CYC   = 3000;
  localparam int RAND_RUNS = 16;

  logic                     clk;
  logic                     rst;
  logic                     replay_mode;
  logic                     record_valid;
  logic                     record_ready;
  logic [`RR_FULL_W-1:0]    record_data;
  logic [31:0]              record_bits;
  logic [CNT_W-1:0]         fill_count;
  logic [`RR_LOGB_CNT-1:0]  chan_valid;
  logic [`RR_LOGB_CNT-1:0]  chan_ready;
  logic [`RR_PAYLOAD_W-1:0] chan_data;
  logic                     replay_unit_valid;
  logic [`RR_LEN_W-1:0]     replay_unit_len;
  logic [`RR_LOGE_CNT-1:0]  replay_loge;

  // Expected payloads per channel, zero extended
  logic [31:0]             exp_ch0 [$];
  logic [31:0]             exp_ch1 [$];
  logic [31:0]             exp_ch2 [$];
  // Expected unit reports in pop order
  logic [`RR_LEN_W-1:0]    exp_len [$];
  logic [`RR_LOGE_CNT-1:0] exp_loge [$];
  logic [31:0]             exp_bits;
  int                      cycles;
  int unsigned             seed_ret;

  rr_storage_backend i_dut (
    .clk               (clk),
    .rst               (rst),
    .replay_mode       (replay_mode),
    .record_valid      (record_valid),
    .record_ready      (record_ready),
    .record_data       (record_data),
    .record_bits       (record_bits),
    .fill_count        (fill_count),
    .chan_valid        (chan_valid),
    .chan_ready        (chan_ready),
    .chan_data         (chan_data),
    .replay_unit_valid (replay_unit_valid),
    .replay_unit_len   (replay_unit_len),
    .replay_loge       (replay_loge)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Hard stop well above the length of all rounds
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYC) begin
      $display("Run stopped after %0d cycles, replay never drained", cycles);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
    $display("Simulation failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic report_error(input string what);
    $display("ERROR: %s", what);
    $display("Simulation failed");
    $fatal(1, "check error");
  endtask

  // Unit length: bitmap and loge bits, plus each set channel's width
  function automatic logic [`RR_LEN_W-1:0] unit_bits(input logic [`RR_LOGB_CNT-1:0] map);
    int n;
    n = `RR_LOGB_CNT + `RR_LOGE_CNT;
    if (map[0]) n += `RR_CH0_W;
    if (map[1]) n += `RR_CH1_W;
    if (map[2]) n += `RR_CH2_W;
    return `RR_LEN_W'(n);
  endfunction

  // Random payload and loge bits around a chosen bitmap
  function automatic logic [`RR_FULL_W-1:0] make_unit(input logic [`RR_LOGB_CNT-1:0] map);
    logic [63:0]             pay;
    logic [`RR_LOGE_CNT-1:0] loge;
    pay  = {$urandom, $urandom};
    loge = `RR_LOGE_CNT'($urandom);
    return {pay[`RR_PAYLOAD_W-1:0], loge, map};
  endfunction

  // Reference model update for one accepted unit
  task automatic log_unit(input logic [`RR_FULL_W-1:0] unit);
    logic [`RR_LOGB_CNT-1:0]  map;
    logic [`RR_PAYLOAD_W-1:0] pay;
    map = unit[`RR_LOGB_CNT-1:0];
    pay = unit[`RR_FULL_W-1 -: `RR_PAYLOAD_W];
    if (map[0]) exp_ch0.push_back(32'(pay[0 +: `RR_CH0_W]));
    if (map[1]) exp_ch1.push_back(32'(pay[`RR_CH0_W +: `RR_CH1_W]));
    if (map[2]) exp_ch2.push_back(32'(pay[`RR_CH0_W + `RR_CH1_W +: `RR_CH2_W]));
    exp_len.push_back(unit_bits(map));
    exp_loge.push_back(unit[`RR_LOGB_CNT +: `RR_LOGE_CNT]);
    exp_bits = exp_bits + 32'(unit_bits(map));
  endtask

  // Compare one delivered payload with the head of its channel queue
  task automatic take_payload(input int ch, input logic [31:0] got);
    logic [31:0] exp;
    int          depth;
    depth = (ch == 0) ? exp_ch0.size() : (ch == 1) ? exp_ch1.size() : exp_ch2.size();
    assert (depth > 0)
      else report_error($sformatf("channel %0d sent a payload never recorded", ch));
    if (ch == 0) exp = exp_ch0.pop_front();
    else if (ch == 1) exp = exp_ch1.pop_front();
    else exp = exp_ch2.pop_front();
    assert (got == exp)
      else report_mismatch($sformatf("chan_data[ch%0d]", ch), 64'(got), 64'(exp));
  endtask

  // Monitor at the falling edge, where all handshakes are settled
  always @(negedge clk) begin : monitor
    logic [`RR_LEN_W-1:0]    len_e;
    logic [`RR_LOGE_CNT-1:0] loge_e;
    if (!rst) begin
      if (record_valid && record_ready) begin
        log_unit(record_data);
      end
      if (chan_valid[0] && chan_ready[0]) take_payload(0, 32'(chan_data[0 +: `RR_CH0_W]));
      if (chan_valid[1] && chan_ready[1]) begin
        take_payload(1, 32'(chan_data[`RR_CH0_W +: `RR_CH1_W]));
      end
      if (chan_valid[2] && chan_ready[2]) begin
        take_payload(2, 32'(chan_data[`RR_CH0_W + `RR_CH1_W +: `RR_CH2_W]));
      end
      if (replay_unit_valid) begin
        assert (exp_len.size() > 0) else report_error("unit report with no unit recorded");
        len_e  = exp_len.pop_front();
        loge_e = exp_loge.pop_front();
        assert (replay_unit_len == len_e)
          else report_mismatch("replay_unit_len", 64'(replay_unit_len), 64'(len_e));
        assert (replay_loge == loge_e)
          else report_mismatch("replay_loge", 64'(replay_loge), 64'(loge_e));
      end
    end
  end

  // Record mode keeps the replay side quiet
  a_record_quiet: assert property (@(posedge clk) disable iff (rst)
    !replay_mode |-> (chan_valid == '0) && !replay_unit_valid)
    else report_error("replay output active while in record mode");

  // Replay mode refuses new units
  a_replay_no_accept: assert property (@(posedge clk) disable iff (rst)
    replay_mode |-> !record_ready)
    else report_error("record_ready high while in replay mode");

  task automatic check_reset_state();
    assert (record_ready == 1'b0) else report_mismatch("record_ready", 64'(record_ready), 0);
    assert (chan_valid == '0) else report_mismatch("chan_valid", 64'(chan_valid), 0);
    assert (replay_unit_valid == 1'b0)
      else report_mismatch("replay_unit_valid", 64'(replay_unit_valid), 0);
    assert (record_bits == '0) else report_mismatch("record_bits", 64'(record_bits), 0);
    assert (fill_count == '0) else report_mismatch("fill_count", 64'(fill_count), 0);
  endtask

  // Fill the buffer, directed rounds walk through every bitmap
  task automatic record_round(input bit directed);
    int idx;
    bit done;
    idx  = 0;
    done = 1'b0;
    @(posedge clk);
    replay_mode  <= 1'b0;
    record_valid <= 1'b1;
    record_data  <= make_unit(directed ? `RR_LOGB_CNT'(idx) : `RR_LOGB_CNT'($urandom));
    while (!done) begin
      @(negedge clk);
      if (record_ready) begin
        idx++;
        // Last free entry, so the unit after it is never offered
        if (fill_count == CNT_W'(`RR_BUF_DEPTH - 1)) begin
          @(posedge clk);
          record_valid <= 1'b0;
        end else begin
          @(posedge clk);
          record_data <= make_unit(directed ? `RR_LOGB_CNT'(idx) : `RR_LOGB_CNT'($urandom));
        end
      end else begin
        done = 1'b1;
      end
    end
    assert (fill_count == CNT_W'(`RR_BUF_DEPTH))
      else report_mismatch("fill_count", 64'(fill_count), 64'(`RR_BUF_DEPTH));
    assert (record_bits == exp_bits)
      else report_mismatch("record_bits", 64'(record_bits), 64'(exp_bits));
  endtask

  // Replay until buffer, lanes and report strobe are all idle
  task automatic replay_round(input bit rand_ready);
    bit drained;
    drained = 1'b0;
    @(posedge clk);
    replay_mode <= 1'b1;
    chan_ready  <= rand_ready ? `RR_LOGB_CNT'($urandom) : '1;
    while (!drained) begin
      @(negedge clk);
      drained = (fill_count == '0) && (chan_valid == '0) && !replay_unit_valid;
      @(posedge clk);
      chan_ready <= rand_ready ? `RR_LOGB_CNT'($urandom) : '1;
    end
  endtask

  initial begin
    seed_ret     = $urandom(63598);
    rst          = 1'b1;
    replay_mode  = 1'b0;
    record_valid = 1'b0;
    record_data  = '0;
    chan_ready   = '0;
    exp_bits     = '0;
    cycles       = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_reset_state();
    // All eight bitmaps in order, outputs always ready
    record_round(1'b1);
    replay_round(1'b0);
    // Random bitmaps with random back-pressure per lane
    for (int r = 0; r < RAND_RUNS; r++) begin
      record_round(1'b0);
      replay_round(1'b1);
    end
    // Nothing may be left over in any channel
    assert (exp_ch0.size() == 0) else report_error("channel 0 payloads never replayed");
    assert (exp_ch1.size() == 0) else report_error("channel 1 payloads never replayed");
    assert (exp_ch2.size() == 0) else report_error("channel 2 payloads never replayed");
    assert (exp_len.size() == 0) else report_error("unit reports missing after replay");
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== rtl/rr_storage_backend.sv ====
`timescale 1ns/10ps
`include "rr_settings.svh"

module rr_storage_backend (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  replay_mode,
  input  logic                                  record_valid,
  output logic                                  record_ready,
  input  logic [`RR_FULL_W-1:0]                 record_data,
  output logic [31:0]                           record_bits,
  output logic [$clog2(`RR_BUF_DEPTH + 1)-1:0] fill_count,
  output logic [`RR_LOGB_CNT-1:0]               chan_valid,
  input  logic [`RR_LOGB_CNT-1:0]               chan_ready,
  output logic [`RR_PAYLOAD_W-1:0]              chan_data,
  output logic                                  replay_unit_valid,
  output logic [`RR_LEN_W-1:0]                  replay_unit_len,
  output logic [`RR_LOGE_CNT-1:0]               replay_loge
);
  import rr_pkg::*;

  // Record side into buffer
  logic                     wr_en;
  logic [`RR_FULL_W-1:0]    wr_data;
  logic                     buf_full;
  // Buffer head toward parser
  logic [`RR_FULL_W-1:0]    head;
  logic                     not_empty;
  logic                     pop;
  // Parser to lanes
  logic [`RR_LOGB_CNT-1:0]  lane_busy;
  logic [`RR_LOGB_CNT-1:0]  lane_load;
  logic [`RR_PAYLOAD_W-1:0] lane_payload;

  rr_record_gate i_record_gate (
    .clk          (clk),
    .rst          (rst),
    .replay_mode  (replay_mode),
    .record_valid (record_valid),
    .record_ready (record_ready),
    .record_data  (record_data),
    .buf_full     (buf_full),
    .wr_en        (wr_en),
    .wr_data      (wr_data),
    .record_bits  (record_bits)
  );

  // Single buffer shared by record and replay
  rr_log_buffer i_log_buffer (
    .clk        (clk),
    .rst        (rst),
    .wr_en      (wr_en),
    .wr_data    (wr_data),
    .pop        (pop),
    .head       (head),
    .not_empty  (not_empty),
    .full       (buf_full),
    .fill_count (fill_count)
  );

  rr_replay_parser i_replay_parser (
    .clk               (clk),
    .rst               (rst),
    .replay_mode       (replay_mode),
    .head              (head),
    .not_empty         (not_empty),
    .pop               (pop),
    .lane_busy         (lane_busy),
    .lane_load         (lane_load),
    .lane_payload      (lane_payload),
    .replay_unit_valid (replay_unit_valid),
    .replay_unit_len   (replay_unit_len),
    .replay_loge       (replay_loge)
  );

  // One lane per logb channel, each at its own width
  for (genvar i = 0; i < `RR_LOGB_CNT; i++) begin : g_lane
    localparam int OFF = rr_ch_offset(i);
    localparam int W   = (i == 0) ? `RR_CH0_W : (i == 1) ? `RR_CH1_W : `RR_CH2_W;

    rr_channel_replayer #(
      .WIDTH (W)
    ) i_lane (
      .clk        (clk),
      .rst        (rst),
      .load       (lane_load[i]),
      .payload    (lane_payload[OFF +: W]),
      .busy       (lane_busy[i]),
      .chan_valid (chan_valid[i]),
      .chan_ready (chan_ready[i]),
      .chan_data  (chan_data[OFF +: W])
    );
  end

endmodule

// ==== rtl/rr_channel_replayer.sv ====
`timescale 1ns/10ps

module rr_channel_replayer #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             load,
  input  logic [WIDTH-1:0] payload,
  output logic             busy,
  output logic             chan_valid,
  input  logic             chan_ready,
  output logic [WIDTH-1:0] chan_data
);

  // Entry state, fill on load, drain on ready
  always_ff @(posedge clk) begin
    if (rst) begin
      chan_valid <= 1'b0;
    end else if (load) begin
      chan_valid <= 1'b1;
    end else if (chan_ready) begin
      chan_valid <= 1'b0;
    end
  end

  // Held payload
  always_ff @(posedge clk) begin
    if (load) begin
      chan_data <= payload;
    end
  end

  // Free only once the consumer took the old payload
  assign busy = chan_valid;

  // Stalled output holds valid and data
  property p_hold_stalled;
    @(posedge clk) disable iff (rst)
      chan_valid && !chan_ready |=> chan_valid && $stable(chan_data);
  endproperty

  a_hold_stalled: assert property (p_hold_stalled)
    else $error("lane dropped stalled payload %h", chan_data);

endmodule

// ==== rtl/rr_replay_parser.sv ====
`timescale 1ns/10ps
`include "rr_settings.svh"

module rr_replay_parser (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     replay_mode,
  input  logic [`RR_FULL_W-1:0]    head,
  input  logic                     not_empty,
  output logic                     pop,
  input  logic [`RR_LOGB_CNT-1:0]  lane_busy,
  output logic [`RR_LOGB_CNT-1:0]  lane_load,
  output logic [`RR_PAYLOAD_W-1:0] lane_payload,
  output logic                     replay_unit_valid,
  output logic [`RR_LEN_W-1:0]     replay_unit_len,
  output logic [`RR_LOGE_CNT-1:0]  replay_loge
);
  import rr_pkg::*;

  // Decoded head unit
  rr_unit_t                head_unit;
  // Lanes this unit needs
  logic [`RR_LOGB_CNT-1:0] need;

  assign head_unit.raw = head;
  assign need          = head_unit.fields.logb_valid;

  // Pop once every needed lane is free
  // Lanes outside the bitmap may stay stalled
  // Empty bitmap pops at once
  assign pop = replay_mode && not_empty && ((need & lane_busy) == '0);

  // Load strobe only for channels set in the bitmap
  assign lane_load = pop ? need : '0;

  // Per-channel payload slice, zero when the channel is absent
  for (genvar g = 0; g < `RR_LOGB_CNT; g++) begin : g_slice
    localparam int OFF = rr_ch_offset(g);
    localparam int W   = rr_ch_offset(g + 1) - OFF;

    assign lane_payload[OFF +: W] = need[g] ? head_unit.fields.payload[OFF +: W] : '0;
  end

  // One-cycle report strobe per popped unit
  always_ff @(posedge clk) begin
    if (rst) begin
      replay_unit_valid <= 1'b0;
    end else begin
      replay_unit_valid <= pop;
    end
  end

  // Report payload, valid only with the strobe
  always_ff @(posedge clk) begin
    if (pop) begin
      replay_unit_len <= rr_unit_len(head_unit);
      replay_loge     <= head_unit.fields.loge_valid;
    end
  end

  // Each loaded lane reports busy from the next cycle on
  // That keeps a later unit from overwriting its payload
  a_load_sets_busy: assert property (
    @(posedge clk) disable iff (rst)
      (lane_load != '0) |=> ((lane_busy & $past(lane_load)) == $past(lane_load)))
    else $error("loaded lane not busy: load %h busy %h", $past(lane_load), lane_busy);

endmodule

// ==== rtl/rr_log_buffer.sv ====
`timescale 1ns/10ps
`include "rr_settings.svh"

module rr_log_buffer (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  wr_en,
  input  logic [`RR_FULL_W-1:0]                 wr_data,
  input  logic                                  pop,
  output logic [`RR_FULL_W-1:0]                 head,
  output logic                                  not_empty,
  output logic                                  full,
  output logic [$clog2(`RR_BUF_DEPTH + 1)-1:0] fill_count
);

  localparam int PTR_W = $clog2(`RR_BUF_DEPTH);
  localparam int CNT_W = $clog2(`RR_BUF_DEPTH + 1);

  // Unit storage
  logic [`RR_FULL_W-1:0] mem [`RR_BUF_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;

  // Store incoming unit
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Pointers wrap at the last entry
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(`RR_BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`RR_BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy, steady when write and pop coincide
  always_ff @(posedge clk) begin
    if (rst) begin
      fill_count <= '0;
    end else if (wr_en && !pop) begin
      fill_count <= fill_count + 1'b1;
    end else if (pop && !wr_en) begin
      fill_count <= fill_count - 1'b1;
    end
  end

  // Show-ahead read
  assign head      = mem[rd_ptr];
  assign not_empty = (fill_count != '0);
  assign full      = (fill_count == CNT_W'(`RR_BUF_DEPTH));

  // Writer must respect full
  a_no_write_full: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full)
    else $error("buffer write while full");

  // Reader must respect empty
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> not_empty)
    else $error("buffer pop while empty");

endmodule

// ==== rtl/rr_record_gate.sv ====
`timescale 1ns/10ps
`include "rr_settings.svh"

module rr_record_gate (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  replay_mode,
  input  logic                  record_valid,
  output logic                  record_ready,
  input  logic [`RR_FULL_W-1:0] record_data,
  input  logic                  buf_full,
  output logic                  wr_en,
  output logic [`RR_FULL_W-1:0] wr_data,
  output logic [31:0]           record_bits
);
  import rr_pkg::*;

  // Field view of the incoming unit
  rr_unit_t rec_unit;
  // Opens one cycle after reset is released
  logic     rec_armed;

  assign rec_unit.raw = record_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      rec_armed <= 1'b0;
    end else begin
      rec_armed <= 1'b1;
    end
  end

  // Accept only in record mode and while the buffer has room
  assign record_ready = rec_armed && !replay_mode && !buf_full;

  // Every transfer is one buffer write, stored at full width
  assign wr_en   = record_valid && record_ready;
  assign wr_data = record_data;

  // Running total of logged bits
  always_ff @(posedge clk) begin
    if (rst) begin
      record_bits <= '0;
    end else if (wr_en) begin
      record_bits <= record_bits + 32'(rr_unit_len(rec_unit));
    end
  end

  // Producer keeps data steady while stalled
  property p_rec_data_stable;
    @(posedge clk) disable iff (rst)
      record_valid && !record_ready |=> $stable(record_data);
  endproperty

  a_rec_data_stable: assert property (p_rec_data_stable)
    else $error("record_data changed while stalled: %h", record_data);

endmodule

// ==== rtl/rr_pkg.sv ====
`include "rr_settings.svh"

package rr_pkg;

  // One logging unit, LSB first: logb bitmap, loge bits, packed payloads
  typedef union packed {
    logic [`RR_FULL_W-1:0] raw;
    struct packed {
      logic [`RR_PAYLOAD_W-1:0] payload;
      logic [`RR_LOGE_CNT-1:0] loge_valid;
      logic [`RR_LOGB_CNT-1:0] logb_valid;
    } fields;
  } rr_unit_t;

  // Bit offset of a channel inside the payload field
  // Channel RR_LOGB_CNT gives the total payload width
  function automatic int rr_ch_offset(input int ch);
    int widths [`RR_LOGB_CNT];
    int off;
    widths[0] = `RR_CH0_W;
    widths[1] = `RR_CH1_W;
    widths[2] = `RR_CH2_W;
    off = 0;
    for (int j = 0; j < `RR_LOGB_CNT; j++) begin
      if (j < ch) begin
        off += widths[j];
      end
    end
    return off;
  endfunction

  // Length of a unit in bits
  // Bitmap and loge bits always count, payloads only when set
  function automatic logic [`RR_LEN_W-1:0] rr_unit_len(input rr_unit_t unit);
    logic [`RR_LEN_W-1:0] len;
    len = `RR_LEN_W'(`RR_LOGB_CNT + `RR_LOGE_CNT);
    for (int i = 0; i < `RR_LOGB_CNT; i++) begin
      if (unit.fields.logb_valid[i]) begin
        len += `RR_LEN_W'(rr_ch_offset(i + 1) - rr_ch_offset(i));
      end
    end
    return len;
  endfunction

endpackage

// ==== rtl/rr_settings.svh ====
`ifndef RR_SETTINGS_SVH
`define RR_SETTINGS_SVH

// Channel counts of one logging unit
`define RR_LOGB_CNT 3
`define RR_LOGE_CNT 2

// Payload width of each logb channel
`define RR_CH0_W 8
`define RR_CH1_W 16
`define RR_CH2_W 32

// Sum of all channel widths
`define RR_PAYLOAD_W 56
// Payload plus bitmap plus loge bits
`define RR_FULL_W 61
// Wide enough for a length up to RR_FULL_W
`define RR_LEN_W 6

// Units held by the shared buffer
`define RR_BUF_DEPTH 8

`endif
